/* Makefile */
VERILATOR   ?= verilator
TOP         ?= tb_net_tx
RTL_TOP     ?= net_tx
FILELIST    ?= net_tx.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/frame_builder.sv */
`timescale 1ns/10ps

module frame_builder (
  input  logic              tx_clock,
  input  logic              rst_n,
  frame_if.builder          order,
  input  net_tx_pkg::mac_t  local_mac,
  input  net_tx_pkg::byte_t payload_data,
  output logic              payload_take,
  output net_tx_pkg::byte_t tx_byte,
  output logic              tx_valid,
  output logic              tx_last
);

  typedef enum logic [2:0] {
    F_IDLE,
    F_PREAMBLE,
    F_SFD,
    F_DEST,
    F_SRC,
    F_TYPE,
    F_PAYLOAD
  } field_t;

  field_t           field;
  field_t           next_field;
  net_tx_pkg::len_t cnt;
  net_tx_pkg::len_t field_len;
  net_tx_pkg::len_t pay_total;
  logic             field_end;
  logic [15:0]      ether;

  // pick byte idx of a mac, most significant first
  function automatic net_tx_pkg::byte_t mac_byte(net_tx_pkg::mac_t mac, logic [2:0] idx);
    return mac[8 * (5 - int'(idx)) +: 8];
  endfunction

  // ------------------------------
  // field lengths and order
  // ------------------------------

  // payload plus padding
  assign pay_total = (order.length > net_tx_pkg::MIN_PAYLOAD) ?
                     order.length : net_tx_pkg::MIN_PAYLOAD;

  always_comb begin
    case (field)
      F_PREAMBLE: begin
        field_len  = net_tx_pkg::len_t'(net_tx_pkg::PREAMBLE_LEN);
        next_field = F_SFD;
      end
      F_SFD: begin
        field_len  = 16'd1;
        next_field = F_DEST;
      end
      F_DEST: begin
        field_len  = 16'd6;
        next_field = F_SRC;
      end
      F_SRC: begin
        field_len  = 16'd6;
        next_field = F_TYPE;
      end
      F_TYPE: begin
        field_len  = 16'd2;
        next_field = F_PAYLOAD;
      end
      F_PAYLOAD: begin
        field_len  = pay_total;
        next_field = F_IDLE;
      end
      default: begin
        field_len  = 16'd1;
        next_field = F_IDLE;
      end
    endcase
  end

  assign field_end = (cnt == field_len - 16'd1);

  // ------------------------------
  // field sequencer
  // ------------------------------
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      field <= F_IDLE;
      cnt   <= '0;
    end else if (field == F_IDLE) begin
      cnt <= '0;
      if (order.start) begin
        field <= F_PREAMBLE;
      end
    end else if (field_end) begin
      field <= next_field;
      cnt   <= '0;
    end else begin
      cnt <= cnt + 16'd1;
    end
  end

  // ------------------------------
  // byte mux
  // ------------------------------
  assign ether = (order.proto == net_tx_pkg::PT_ARP) ? net_tx_pkg::ETH_ARP : net_tx_pkg::ETH_IP;

  // source bytes while length lasts, zeros after
  assign payload_take = (field == F_PAYLOAD) && (cnt < order.length);

  always_comb begin
    case (field)
      F_PREAMBLE: tx_byte = net_tx_pkg::PREAMBLE_BYTE;
      F_SFD:      tx_byte = net_tx_pkg::SFD_BYTE;
      F_DEST:     tx_byte = mac_byte(order.dest_mac, cnt[2:0]);
      F_SRC:      tx_byte = mac_byte(local_mac, cnt[2:0]);
      F_TYPE:     tx_byte = cnt[0] ? ether[7:0] : ether[15:8];
      F_PAYLOAD:  tx_byte = payload_take ? payload_data : 8'h00;
      default:    tx_byte = 8'h00;
    endcase
  end

  assign tx_valid   = (field != F_IDLE);
  assign tx_last    = (field == F_PAYLOAD) && field_end;
  assign order.done = tx_last;

  // take only in payload, and the order must not move under it
  a_take_in_payload: assert property (@(posedge tx_clock) disable iff (!rst_n)
    payload_take |-> (field == F_PAYLOAD) && $stable(order.length));

endmodule

/* design/frame_if.sv */
`timescale 1ns/10ps

interface frame_if;

  // one frame order, stable from start until done
  net_tx_pkg::proto_t proto;
  logic               start;
  net_tx_pkg::mac_t   dest_mac;
  net_tx_pkg::len_t   length;
  logic               done;

  // arbiter issues the order
  modport arbiter (output proto, output start, output length, input done);

  // destination block answers with the mac for the granted protocol
  modport dest (input proto, output dest_mac);

  // builder consumes the order and reports the last byte
  modport builder (input proto, input start, input dest_mac, input length, output done);

  // read-only view for the top level
  modport top (input proto, input start, input dest_mac, input length, input done);

endinterface

/* design/net_tx.sv */
`timescale 1ns/10ps

module net_tx (
  input  logic                           tx_clock,
  input  logic                           rst_n,
  input  logic                           run,

  // addresses
  input  net_tx_pkg::mac_t               local_mac,
  input  net_tx_pkg::mac_t               remote_mac,
  input  net_tx_pkg::mac_t               udp_destination_mac,

  // packet sources
  input  logic [net_tx_pkg::NUM_SRC-1:0] src_req,
  input  net_tx_pkg::len_t               src_length [net_tx_pkg::NUM_SRC],
  input  net_tx_pkg::byte_t              payload_data,
  output logic [net_tx_pkg::NUM_SRC-1:0] src_ack,
  output net_tx_pkg::proto_t             tx_grant,
  output logic                           grant_valid,
  output logic                           payload_take,

  // phy
  output net_tx_pkg::byte_t              phy_tx_data,
  output logic                           phy_tx_valid
);

  net_tx_pkg::byte_t tx_byte;
  logic              tx_valid;
  logic              tx_last;
  logic              port_busy;

  frame_if order ();

  // ------------------------------
  // frame order
  // ------------------------------
  tx_arbiter arbiter_inst (
    .tx_clock    (tx_clock),
    .rst_n       (rst_n),
    .src_req     (src_req),
    .src_length  (src_length),
    .port_busy   (port_busy),
    .src_ack     (src_ack),
    .tx_grant    (tx_grant),
    .grant_valid (grant_valid),
    .order       (order.arbiter)
  );

  tx_dest_regs dest_inst (
    .tx_clock            (tx_clock),
    .rst_n               (rst_n),
    .run                 (run),
    .remote_mac          (remote_mac),
    .udp_destination_mac (udp_destination_mac),
    .order               (order.dest)
  );

  // ------------------------------
  // byte stream
  // ------------------------------
  frame_builder builder_inst (
    .tx_clock     (tx_clock),
    .rst_n        (rst_n),
    .order        (order.builder),
    .local_mac    (local_mac),
    .payload_data (payload_data),
    .payload_take (payload_take),
    .tx_byte      (tx_byte),
    .tx_valid     (tx_valid),
    .tx_last      (tx_last)
  );

  phy_tx_port phy_inst (
    .tx_clock     (tx_clock),
    .rst_n        (rst_n),
    .tx_byte      (tx_byte),
    .tx_valid     (tx_valid),
    .tx_last      (tx_last),
    .phy_tx_data  (phy_tx_data),
    .phy_tx_valid (phy_tx_valid),
    .port_busy    (port_busy)
  );

endmodule

/* design/net_tx_pkg.sv */
package net_tx_pkg;

  // ------------------------------
  // basic types
  // ------------------------------

  // source ids, lowest value wins arbitration
  typedef enum logic [1:0] {
    PT_ARP  = 2'd0,
    PT_ICMP = 2'd1,
    PT_DHCP = 2'd2,
    PT_UDP  = 2'd3
  } proto_t;

  typedef logic [7:0]  byte_t;
  typedef logic [47:0] mac_t;
  typedef logic [15:0] len_t;

  // ------------------------------
  // framing constants
  // ------------------------------

  // one req/ack pair per protocol
  localparam int NUM_SRC = 4;

  // preamble and start byte
  localparam int    PREAMBLE_LEN  = 7;
  localparam byte_t PREAMBLE_BYTE = 8'h55;
  localparam byte_t SFD_BYTE      = 8'hD5;

  // short payloads are zero padded up to this
  localparam len_t MIN_PAYLOAD = 16'd46;

  // idle byte times between frames
  localparam int IFG_LEN = 12;

  // ethertypes
  localparam logic [15:0] ETH_ARP = 16'h0806;
  localparam logic [15:0] ETH_IP  = 16'h0800;

  localparam mac_t BROADCAST_MAC = 48'hFFFF_FFFF_FFFF;

endpackage

/* design/phy_tx_port.sv */
`timescale 1ns/10ps

module phy_tx_port (
  input  logic              tx_clock,
  input  logic              rst_n,
  input  net_tx_pkg::byte_t tx_byte,
  input  logic              tx_valid,
  input  logic              tx_last,
  output net_tx_pkg::byte_t phy_tx_data,
  output logic              phy_tx_valid,
  output logic              port_busy
);

  localparam int GAP_W = $clog2(net_tx_pkg::IFG_LEN + 1);

  logic [GAP_W-1:0] gap_cnt;

  // ------------------------------
  // output register
  // ------------------------------

  // data lane, valid qualifies it
  always_ff @(posedge tx_clock) begin
    phy_tx_data <= tx_byte;
  end

  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      phy_tx_valid <= 1'b0;
    end else begin
      phy_tx_valid <= tx_valid;
    end
  end

  // ------------------------------
  // inter-frame gap
  // ------------------------------

  // armed by the last byte, runs down once per clock
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      gap_cnt <= '0;
    end else if (tx_valid && tx_last) begin
      gap_cnt <= GAP_W'(net_tx_pkg::IFG_LEN);
    end else if (gap_cnt != '0) begin
      gap_cnt <= gap_cnt - 1'b1;
    end
  end

  // busy from first byte in until the gap has drained
  assign port_busy = tx_valid || phy_tx_valid || (gap_cnt != '0);

  // the arbiter must hold off the next frame during the gap
  a_no_valid_in_gap: assert property (@(posedge tx_clock) disable iff (!rst_n)
    (gap_cnt != '0) |-> !tx_valid);

endmodule

/* design/tx_arbiter.sv */
`timescale 1ns/10ps

module tx_arbiter (
  input  logic                                tx_clock,
  input  logic                                rst_n,
  input  logic [net_tx_pkg::NUM_SRC-1:0]      src_req,
  input  net_tx_pkg::len_t                    src_length [net_tx_pkg::NUM_SRC],
  input  logic                                port_busy,
  output logic [net_tx_pkg::NUM_SRC-1:0]      src_ack,
  output net_tx_pkg::proto_t                  tx_grant,
  output logic                                grant_valid,
  frame_if.arbiter                            order
);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_BUILD,
    ARB_ACK
  } arb_state_t;

  arb_state_t         state;
  net_tx_pkg::proto_t grant_proto;
  net_tx_pkg::proto_t pick;
  net_tx_pkg::len_t   grant_len;
  logic               start_q;
  logic               no_ack;

  // ------------------------------
  // fixed priority pick
  // ------------------------------

  // walk down so the lowest index is left in pick
  always_comb begin
    pick = net_tx_pkg::PT_UDP;
    for (int i = net_tx_pkg::NUM_SRC - 1; i >= 0; i--) begin
      if (src_req[i]) begin
        pick = net_tx_pkg::proto_t'(i[1:0]);
      end
    end
  end

  assign no_ack = (src_ack == '0);

  // ------------------------------
  // idle / build / ack
  // ------------------------------
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      state       <= ARB_IDLE;
      grant_proto <= net_tx_pkg::PT_ARP;
      grant_len   <= '0;
      start_q     <= 1'b0;
      src_ack     <= '0;
    end else begin
      // start is a single cycle pulse
      start_q <= 1'b0;
      case (state)
        ARB_IDLE: begin
          // wait out the gap before taking the next order
          if ((|src_req) && !port_busy && no_ack) begin
            grant_proto <= pick;
            grant_len   <= src_length[pick];
            start_q     <= 1'b1;
            state       <= ARB_BUILD;
          end
        end
        ARB_BUILD: begin
          if (order.done) begin
            src_ack[grant_proto] <= 1'b1;
            state                <= ARB_ACK;
          end
        end
        ARB_ACK: begin
          // four-phase release of ack once req is gone
          if (!src_req[grant_proto]) begin
            src_ack <= '0;
            state   <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  assign order.proto  = grant_proto;
  assign order.length = grant_len;
  assign order.start  = start_q;

  assign tx_grant    = grant_proto;
  assign grant_valid = (state != ARB_IDLE);

  // ------------------------------
  // checks
  // ------------------------------
  a_ack_onehot: assert property (@(posedge tx_clock) disable iff (!rst_n)
    $onehot0(src_ack));

endmodule

/* design/tx_dest_regs.sv */
`timescale 1ns/10ps

module tx_dest_regs (
  input  logic             tx_clock,
  input  logic             rst_n,
  input  logic             run,
  input  net_tx_pkg::mac_t remote_mac,
  input  net_tx_pkg::mac_t udp_destination_mac,
  frame_if.dest            order
);

  // udp destination as seen when run went high
  net_tx_pkg::mac_t run_dest_mac;

  // ------------------------------
  // run-gated latch
  // ------------------------------

  // follows the host value until streaming starts, then holds
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      run_dest_mac <= '0;
    end else if (!run) begin
      run_dest_mac <= udp_destination_mac;
    end
  end

  // ------------------------------
  // per-protocol destination
  // ------------------------------
  always_comb begin
    case (order.proto)
      // arp requests and dhcp discovery go to everyone
      net_tx_pkg::PT_ARP:  order.dest_mac = net_tx_pkg::BROADCAST_MAC;
      net_tx_pkg::PT_DHCP: order.dest_mac = net_tx_pkg::BROADCAST_MAC;
      // echo replies go back to whoever pinged
      net_tx_pkg::PT_ICMP: order.dest_mac = remote_mac;
      net_tx_pkg::PT_UDP:  order.dest_mac = run_dest_mac;
      default:             order.dest_mac = net_tx_pkg::BROADCAST_MAC;
    endcase
  end

endmodule

/* net_tx.f */
design/net_tx_pkg.sv
design/frame_if.sv
design/tx_arbiter.sv
design/tx_dest_regs.sv
design/frame_builder.sv
design/phy_tx_port.sv
design/net_tx.sv
verification/tb_clock_gen.sv
verification/tb_net_tx.sv

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
  output logic tx_clock,
  output logic rst_n
);

  // 4 ns period
  localparam int HALF_PERIOD_NS = 2;
  localparam int RESET_CYCLES   = 10;

  initial begin
    tx_clock = 1'b0;
    forever #(HALF_PERIOD_NS) tx_clock = ~tx_clock;
  end

  // release on a falling edge, away from the flops
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge tx_clock);
    @(negedge tx_clock);
    rst_n = 1'b1;
  end

endmodule

/* verification/tb_net_tx.sv */
`timescale 1ns/10ps

module tb_net_tx;

  localparam int CLK_PERIOD_NS = 4;
  localparam int NUM_ROWS      = 7;
  // preamble, sfd, two macs, ethertype
  localparam int HDR_BYTES     = 22;

  typedef struct packed {
    logic [net_tx_pkg::NUM_SRC-1:0]                   req;
    net_tx_pkg::len_t [net_tx_pkg::NUM_SRC-1:0]       len;
    logic                                             run;
    net_tx_pkg::mac_t                                 mac_before;
    net_tx_pkg::mac_t                                 mac_after;
  } row_t;

  logic                           tx_clock;
  logic                           rst_n;
  logic                           run;
  net_tx_pkg::mac_t               local_mac;
  net_tx_pkg::mac_t               remote_mac;
  net_tx_pkg::mac_t               udp_destination_mac;
  logic [net_tx_pkg::NUM_SRC-1:0] src_req;
  net_tx_pkg::len_t               src_length [net_tx_pkg::NUM_SRC];
  net_tx_pkg::byte_t              payload_data;
  logic [net_tx_pkg::NUM_SRC-1:0] src_ack;
  net_tx_pkg::proto_t             tx_grant;
  logic                           grant_valid;
  logic                           payload_take;
  net_tx_pkg::byte_t              phy_tx_data;
  logic                           phy_tx_valid;

  row_t              test_table [NUM_ROWS];
  bit                table_ready = 1'b0;
  net_tx_pkg::byte_t pay_mem [net_tx_pkg::NUM_SRC][256];

  // capture results, written only by the capture process
  net_tx_pkg::byte_t  cap_bytes [$];
  int                 cap_starts [$];
  int                 cap_lens [$];
  net_tx_pkg::proto_t cap_grants [$];
  int                 gap_errors = 0;

  int error_count = 0;
  int check_count = 0;

  tb_clock_gen clock_gen (
    .tx_clock (tx_clock),
    .rst_n    (rst_n)
  );

  net_tx UUT (
    .tx_clock            (tx_clock),
    .rst_n               (rst_n),
    .run                 (run),
    .local_mac           (local_mac),
    .remote_mac          (remote_mac),
    .udp_destination_mac (udp_destination_mac),
    .src_req             (src_req),
    .src_length          (src_length),
    .payload_data        (payload_data),
    .src_ack             (src_ack),
    .tx_grant            (tx_grant),
    .grant_valid         (grant_valid),
    .payload_take        (payload_take),
    .phy_tx_data         (phy_tx_data),
    .phy_tx_valid        (phy_tx_valid)
  );

  // ------------------------------
  // stimulus table
  // ------------------------------

  function automatic net_tx_pkg::mac_t random_mac();
    return {16'($urandom()), 32'($urandom())};
  endfunction

  // a nonzero length means the source requests
  function automatic row_t make_row(input int l_arp, input int l_icmp, input int l_dhcp,
                                    input int l_udp, input logic run_level);
    row_t row;
    row.len        = {16'(l_udp), 16'(l_dhcp), 16'(l_icmp), 16'(l_arp)};
    row.req        = {l_udp != 0, l_dhcp != 0, l_icmp != 0, l_arp != 0};
    row.run        = run_level;
    row.mac_before = random_mac();
    row.mac_after  = random_mac();
    return row;
  endfunction

  task automatic fill_table();
    //                        arp icmp dhcp udp  run
    test_table[0] = make_row(  0,   0,   0,  60, 1'b0);
    test_table[1] = make_row( 10,   0,   0,   0, 1'b0);
    test_table[2] = make_row( 20,  46,  50,  30, 1'b0);
    // dest frozen while run is high
    test_table[3] = make_row(  0,   0,   0,  47, 1'b1);
    test_table[4] = make_row(  0,   3,   0,  46, 1'b0);
    test_table[5] = make_row(  1,   0,   0,  70, 1'b1);
    test_table[6] = make_row( 46,  47,  45, 100, 1'b0);
  endtask

  // ------------------------------
  // expected values
  // ------------------------------

  function automatic net_tx_pkg::mac_t expected_dest(input net_tx_pkg::proto_t p,
                                                     input net_tx_pkg::mac_t udp_dest);
    case (p)
      net_tx_pkg::PT_ICMP: return remote_mac;
      net_tx_pkg::PT_UDP:  return udp_dest;
      default:             return 48'hFFFF_FFFF_FFFF;
    endcase
  endfunction

  // byte k of a frame, counted from the first preamble byte
  function automatic net_tx_pkg::byte_t expected_byte(input net_tx_pkg::proto_t p, input int k,
                                                      input int len, input net_tx_pkg::mac_t dest);
    logic [15:0] etype;
    etype = (p == net_tx_pkg::PT_ARP) ? 16'h0806 : 16'h0800;
    if (k < 7) return 8'h55;
    if (k == 7) return 8'hD5;
    if (k < 14) return dest[8 * (13 - k) +: 8];
    if (k < 20) return local_mac[8 * (19 - k) +: 8];
    if (k == 20) return etype[15:8];
    if (k == 21) return etype[7:0];
    if (k - HDR_BYTES < len) return pay_mem[int'(p)][k - HDR_BYTES];
    return 8'h00;
  endfunction

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic check_byte(input net_tx_pkg::byte_t got, input net_tx_pkg::byte_t exp,
                            input string what, output bit ok);
    check_count++;
    ok = (got === exp);
    if (!ok) begin
      error_count++;
      $display("FAIL %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
    end
  endtask

  task automatic check_mac(input net_tx_pkg::mac_t got, input net_tx_pkg::mac_t exp,
                           input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL %0t: %s is %012h, expected %012h", $time, what, got, exp);
    end
  endtask

  task automatic check_proto(input net_tx_pkg::proto_t got, input net_tx_pkg::proto_t exp,
                             input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  // one captured frame against the rules
  task automatic check_frame(input int r, input int f, input net_tx_pkg::proto_t p,
                             input int len, input net_tx_pkg::mac_t dest);
    int               exp_len;
    int               got_len;
    int               base;
    net_tx_pkg::mac_t got_mac;
    bit               ok;
    exp_len = HDR_BYTES + ((len > int'(net_tx_pkg::MIN_PAYLOAD)) ?
                           len : int'(net_tx_pkg::MIN_PAYLOAD));
    got_len = cap_lens[f];
    base    = cap_starts[f];
    check_proto(cap_grants[f], p, $sformatf("test %0d frame %0d grant", r, f));
    if (got_len != exp_len) begin
      error_count++;
      $display("FAIL %0t: test %0d frame %0d has %0d bytes, expected %0d",
               $time, r, f, got_len, exp_len);
    end
    if (got_len >= 20) begin
      got_mac = '0;
      for (int k = 0; k < 6; k++) begin
        got_mac = {got_mac[39:0], cap_bytes[base + 8 + k]};
      end
      check_mac(got_mac, dest, $sformatf("test %0d frame %0d dest mac", r, f));
      for (int k = 0; k < 6; k++) begin
        got_mac = {got_mac[39:0], cap_bytes[base + 14 + k]};
      end
      check_mac(got_mac, local_mac, $sformatf("test %0d frame %0d source mac", r, f));
    end
    // stop at the first bad byte of a frame
    for (int k = 0; k < got_len && k < exp_len; k++) begin
      check_byte(cap_bytes[base + k], expected_byte(p, k, len, dest),
                 $sformatf("test %0d frame %0d byte %0d", r, f, k), ok);
      if (!ok) break;
    end
  endtask

  // ------------------------------
  // source models
  // ------------------------------

  // four-phase req/ack for every source in the set
  task automatic run_sources(input logic [net_tx_pkg::NUM_SRC-1:0] req_set);
    logic [net_tx_pkg::NUM_SRC-1:0] pending;
    pending = req_set;
    @(negedge tx_clock);
    src_req = req_set;
    while (pending != '0) begin
      @(negedge tx_clock);
      if ((src_ack & ~pending) != '0) begin
        error_count++;
        $display("ack %b raised for a source that has no request", src_ack);
      end
      for (int i = 0; i < net_tx_pkg::NUM_SRC; i++) begin
        if (pending[i]) begin
          if (src_req[i] && src_ack[i]) begin
            src_req[i] = 1'b0;
          end else if (!src_req[i] && !src_ack[i]) begin
            pending[i] = 1'b0;
          end
        end
      end
    end
  endtask

  // granted source presents byte k until the take is seen
  initial begin
    int pay_idx;
    bit take_prev;
    payload_data = '0;
    pay_idx      = 0;
    take_prev    = 1'b0;
    forever begin
      @(negedge tx_clock);
      if (!grant_valid) begin
        pay_idx = 0;
      end else if (take_prev) begin
        pay_idx++;
      end
      take_prev    = payload_take;
      payload_data = pay_mem[int'(tx_grant)][pay_idx];
    end
  end

  // ------------------------------
  // frame capture
  // ------------------------------
  initial begin
    int idle_run;
    int frame_bytes;
    bit in_frame;
    idle_run    = 0;
    frame_bytes = 0;
    in_frame    = 1'b0;
    forever begin
      @(negedge tx_clock);
      if (phy_tx_valid) begin
        if (!in_frame) begin
          // gap only matters once a frame has gone out
          if (cap_lens.size() > 0 && idle_run < net_tx_pkg::IFG_LEN) begin
            gap_errors++;
            $display("only %0d idle cycles before frame %0d, at least %0d needed",
                     idle_run, cap_lens.size(), net_tx_pkg::IFG_LEN);
          end
          cap_grants.push_back(tx_grant);
          cap_starts.push_back(cap_bytes.size());
          in_frame    = 1'b1;
          frame_bytes = 0;
        end
        cap_bytes.push_back(phy_tx_data);
        frame_bytes++;
      end else begin
        if (in_frame) begin
          cap_lens.push_back(frame_bytes);
          in_frame = 1'b0;
          idle_run = 0;
        end
        idle_run++;
      end
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------

  task automatic check_idle_after_reset();
    int errs_before;
    errs_before = error_count;
    repeat (5) begin
      @(negedge tx_clock);
      if (phy_tx_valid || grant_valid || payload_take || (src_ack != '0)) begin
        error_count++;
        $display("an output is active after reset with no request pending");
      end
    end
    $display("test reset: idle outputs, %0d errors", error_count - errs_before);
  endtask

  task automatic apply_row(input int r);
    row_t             row;
    net_tx_pkg::mac_t udp_expect;
    int               first_frame;
    int               n_expect;
    int               frame;
    int               errs_before;
    row         = test_table[r];
    errs_before = error_count + gap_errors;
    // latch follows mac_before, then run decides whether mac_after gets in
    @(negedge tx_clock);
    run                 = 1'b0;
    udp_destination_mac = row.mac_before;
    repeat (2) @(negedge tx_clock);
    run = row.run;
    @(negedge tx_clock);
    udp_destination_mac = row.mac_after;
    repeat (2) @(negedge tx_clock);
    udp_expect = row.run ? row.mac_before : row.mac_after;
    for (int i = 0; i < net_tx_pkg::NUM_SRC; i++) begin
      src_length[i] = row.len[i];
      for (int k = 0; k < int'(row.len[i]); k++) begin
        pay_mem[i][k] = 8'($urandom());
      end
    end
    first_frame = cap_lens.size();
    n_expect    = $countones(row.req);
    run_sources(row.req);
    while (cap_lens.size() < first_frame + n_expect) @(negedge tx_clock);
    repeat (4) @(negedge tx_clock);
    if (cap_lens.size() != first_frame + n_expect) begin
      error_count++;
      $display("test %0d produced %0d frames instead of %0d",
               r, cap_lens.size() - first_frame, n_expect);
    end
    // priority order is the order of the proto values
    frame = first_frame;
    for (int p = 0; p < net_tx_pkg::NUM_SRC; p++) begin
      if (row.req[p]) begin
        check_frame(r, frame, net_tx_pkg::proto_t'(p), int'(row.len[p]),
                    expected_dest(net_tx_pkg::proto_t'(p), udp_expect));
        frame++;
      end
    end
    $display("test %0d: %0d frames, run %0b, %0d errors",
             r, n_expect, row.run, error_count + gap_errors - errs_before);
  endtask

  initial begin
    int total_errors;
    void'($urandom(34477));
    run                 = 1'b0;
    src_req             = '0;
    udp_destination_mac = '0;
    for (int i = 0; i < net_tx_pkg::NUM_SRC; i++) begin
      src_length[i] = '0;
    end
    local_mac  = random_mac();
    remote_mac = random_mac();
    fill_table();
    table_ready = 1'b1;
    wait (rst_n === 1'b1);
    check_idle_after_reset();
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(r);
    end
    total_errors = error_count + gap_errors;
    $display("tests %0d, checks %0d, errors %0d", NUM_ROWS + 1, check_count, total_errors);
    if (total_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // ------------------------------
  // watchdog
  // ------------------------------

  // every frame plus its gap, and slack per row for setup and handshakes
  initial begin
    longint limit_cycles;
    int     len;
    wait (table_ready);
    limit_cycles = 50;
    for (int r = 0; r < NUM_ROWS; r++) begin
      limit_cycles += 200;
      for (int p = 0; p < net_tx_pkg::NUM_SRC; p++) begin
        if (test_table[r].req[p]) begin
          len = int'(test_table[r].len[p]);
          if (len < int'(net_tx_pkg::MIN_PAYLOAD)) len = int'(net_tx_pkg::MIN_PAYLOAD);
          limit_cycles += HDR_BYTES + len + net_tx_pkg::IFG_LEN;
        end
      end
    end
    #(limit_cycles * CLK_PERIOD_NS);
    $display("timeout: the tests did not finish within %0d cycles", limit_cycles);
    $display("TB FAILED");
    $finish;
  end

endmodule
